/* verilog/fpu_pkg.sv */
package fpu_pkg;

    localparam int FLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int EXP_BIAS = 127;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RV32F encodings
    localparam logic [6:0] OP_FP  = 7'b1010011;  // Arithmetic, convert, move
    localparam logic [6:0] OP_FLW = 7'b0000111;
    localparam logic [6:0] OP_FSW = 7'b0100111;

    localparam logic [2:0] F3_WORD = 3'b010;     // Width field of flw and fsw
    localparam logic [2:0] F3_MV   = 3'b000;     // fmv.x.w, as opposed to fclass

    localparam logic [4:0] F5_ADD    = 5'b00000;
    localparam logic [4:0] F5_SUB    = 5'b00001;
    localparam logic [4:0] F5_MUL    = 5'b00010;
    localparam logic [4:0] F5_CVT_WS = 5'b11000;  // Float to int
    localparam logic [4:0] F5_CVT_SW = 5'b11010;  // Int to float
    localparam logic [4:0] F5_MV_XW  = 5'b11100;
    localparam logic [4:0] F5_MV_WX  = 5'b11110;

    // First stage whose result register holds the value
    typedef enum logic [1:0] {
        RDY_2 = 2'd0,
        RDY_3 = 2'd1,
        RDY_4 = 2'd2
    } rdy_t;

endpackage

/* verilog/fpu_decode.sv */
`timescale 1ns/1ns

module fpu_decode (
    input  logic [6:0]    opcode,
    input  logic [4:0]    funct5,
    input  logic [2:0]    funct3,
    output logic          reg_write,
    output logic          is_sub,
    output logic          is_adsb,
    output logic          is_mult,
    output logic          is_load,
    output logic          is_cvif,
    output logic          is_ftoi,
    output logic          is_cvrt,
    output logic          use_rs1,
    output logic          use_rs2,
    output fpu_pkg::rdy_t rdy
);
    import fpu_pkg::*;

    always_comb begin
        reg_write = 1'b0;
        is_sub    = 1'b0;
        is_adsb   = 1'b0;
        is_mult   = 1'b0;
        is_load   = 1'b0;
        is_cvif   = 1'b0;
        is_ftoi   = 1'b0;
        is_cvrt   = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        rdy       = RDY_2;
        if (opcode == OP_FP) begin
            case (funct5)
                F5_ADD, F5_SUB: begin
                    reg_write = 1'b1;
                    is_adsb   = 1'b1;
                    is_sub    = (funct5 == F5_SUB);
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    rdy       = RDY_3;
                end
                F5_MUL: begin
                    reg_write = 1'b1;
                    is_mult   = 1'b1;
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    rdy       = RDY_4;
                end
                F5_CVT_WS: begin
                    is_ftoi = 1'b1;
                    is_cvrt = 1'b1;
                    use_rs1 = 1'b1;
                end
                F5_MV_XW: begin
                    is_ftoi = (funct3 == F3_MV);
                    use_rs1 = (funct3 == F3_MV);
                end
                F5_CVT_SW: begin
                    reg_write = 1'b1;
                    is_cvif   = 1'b1;
                    rdy       = RDY_3;
                end
                F5_MV_WX: begin
                    reg_write = 1'b1;  // from_intreg lands in result_2
                end
                default: begin
                end
            endcase
        end else if (opcode == OP_FLW && funct3 == F3_WORD) begin
            reg_write = 1'b1;
            is_load   = 1'b1;
            rdy       = RDY_4;
        end else if (opcode == OP_FSW && funct3 == F3_WORD) begin
            use_rs2 = 1'b1;  // Base address comes from the integer side
        end
    end

endmodule

/* verilog/fpu_dependency.sv */
`timescale 1ns/1ns

module fpu_dependency (
    input  logic                       clk,
    input  logic [fpu_pkg::REG_AW-1:0] rs1,
    input  logic [fpu_pkg::REG_AW-1:0] rs2,
    input  logic                       use_rs1,
    input  logic                       use_rs2,
    input  logic [fpu_pkg::REG_AW-1:0] rd_1,
    input  logic [fpu_pkg::REG_AW-1:0] rd_2,
    input  logic [fpu_pkg::REG_AW-1:0] rd_3,
    input  logic [fpu_pkg::REG_AW-1:0] rd_4,
    input  logic                       wr_1,
    input  logic                       wr_2,
    input  logic                       wr_3,
    input  logic                       wr_4,
    input  fpu_pkg::rdy_t              rdy_1,
    input  fpu_pkg::rdy_t              rdy_2,
    input  fpu_pkg::rdy_t              rdy_3,
    output logic                       hazard,
    output logic [1:0]                 fwd1_sel,
    output logic [1:0]                 fwd2_sel
);
    import fpu_pkg::*;

    logic [REG_AW-1:0] rs1_q;
    logic [REG_AW-1:0] rs2_q;
    logic              use1_q;
    logic              use2_q;
    logic [3:1]        late;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 0 stall: writer at stage s not ready by s+1
    assign late[1] = wr_1 && (rdy_1 > RDY_2);
    assign late[2] = wr_2 && (rdy_2 > RDY_3);
    assign late[3] = wr_3 && (rdy_3 > RDY_4);

    function automatic logic blocked(input logic [REG_AW-1:0] rs, input logic use_rs);
        blocked = use_rs && ((late[1] && rs == rd_1) || (late[2] && rs == rd_2)
                          || (late[3] && rs == rd_3));
    endfunction

    // Stage 1 forward select, 1..3 pick result_2..result_4
    function automatic logic [1:0] pick(input logic [REG_AW-1:0] rs, input logic use_rs);
        if (!use_rs)
            pick = 2'd0;
        else if (wr_2 && rs == rd_2)
            pick = 2'd1;  // Youngest first
        else if (wr_3 && rs == rd_3)
            pick = 2'd2;
        else if (wr_4 && rs == rd_4)
            pick = 2'd3;
        else
            pick = 2'd0;
    endfunction

    always_comb begin
        hazard   = blocked(rs1, use_rs1) || blocked(rs2, use_rs2);
        fwd1_sel = pick(rs1_q, use1_q);
        fwd2_sel = pick(rs2_q, use2_q);
    end

    always_ff @(posedge clk) begin
        rs1_q  <= rs1;
        rs2_q  <= rs2;
        use1_q <= use_rs1;
        use2_q <= use_rs2;
    end

endmodule

/* verilog/float_register.sv */
`timescale 1ns/1ns

module float_register (
    input  logic                       clk,
    input  logic [fpu_pkg::REG_AW-1:0] rs1,
    input  logic [fpu_pkg::REG_AW-1:0] rs2,
    input  logic [fpu_pkg::REG_AW-1:0] rd,
    input  logic [fpu_pkg::FLEN-1:0]   wdata,
    input  logic                       we,
    output logic [fpu_pkg::FLEN-1:0]   rdata1,
    output logic [fpu_pkg::FLEN-1:0]   rdata2
);
    import fpu_pkg::*;

    logic [FLEN-1:0] regs [0:(1 << REG_AW) - 1];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[rd] <= wdata;
        end
        rdata1 <= (we && rd == rs1) ? wdata : regs[rs1];  // Write-first
        rdata2 <= (we && rd == rs2) ? wdata : regs[rs2];
    end

endmodule

/* verilog/fp_addsub.sv */
`timescale 1ns/1ns

module fp_addsub (
    input  logic                     clk,
    input  logic [fpu_pkg::FLEN-1:0] a,
    input  logic [fpu_pkg::FLEN-1:0] b,
    input  logic                     is_sub,
    output logic [fpu_pkg::FLEN-1:0] sum
);

    logic [31:0] b_eff;
    logic [31:0] op_hi;
    logic [31:0] op_lo;
    logic [24:0] man_hi;   // Hidden bit, fraction, one guard bit
    logic [24:0] man_lo;
    logic [7:0]  diff;
    logic [25:0] man_sum;

    logic        sgn_q;
    logic [7:0]  exp_q;
    logic [25:0] sum_q;

    logic [4:0]  lz;
    logic [25:0] norm;
    logic [9:0]  exp_n;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage A: order by magnitude, align, add
    assign b_eff = {b[31] ^ is_sub, b[30:0]};

    always_comb begin
        if (b_eff[30:0] > a[30:0]) begin
            op_hi = b_eff;
            op_lo = a;
        end else begin
            op_hi = a;
            op_lo = b_eff;
        end
        man_hi = (op_hi[30:23] == 8'd0) ? 25'd0 : {1'b1, op_hi[22:0], 1'b0};
        man_lo = (op_lo[30:23] == 8'd0) ? 25'd0 : {1'b1, op_lo[22:0], 1'b0};
        diff   = op_hi[30:23] - op_lo[30:23];
        if (op_hi[31] != op_lo[31]) begin
            man_sum = {1'b0, man_hi} - {1'b0, man_lo >> diff};
        end else begin
            man_sum = {1'b0, man_hi} + {1'b0, man_lo >> diff};
        end
    end

    always_ff @(posedge clk) begin
        sgn_q <= op_hi[31];
        exp_q <= op_hi[30:23];
        sum_q <= man_sum;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage B: normalise, truncate, flush
    always_comb begin
        lz = 5'd26;
        for (int i = 0; i < 26; i++) begin
            if (sum_q[i]) begin
                lz = 5'(25 - i);
            end
        end
        norm  = sum_q << lz;
        exp_n = {2'b00, exp_q} + 10'd1 - {5'd0, lz};
        if (sum_q == 26'd0) begin
            sum = '0;                       // Exact cancel gives +0
        end else if (exp_n[9] || exp_n == 10'd0) begin
            sum = {sgn_q, 31'd0};
        end else begin
            sum = {sgn_q, exp_n[7:0], norm[24:2]};
        end
    end

endmodule

/* verilog/fp_mult.sv */
`timescale 1ns/1ns

module fp_mult (
    input  logic                     clk,
    input  logic [fpu_pkg::FLEN-1:0] a,
    input  logic [fpu_pkg::FLEN-1:0] b,
    output logic [fpu_pkg::FLEN-1:0] product
);
    import fpu_pkg::*;

    logic        sgn_1;
    logic        zero_1;
    logic [9:0]  exp_1;    // Biased, may go negative
    logic [23:0] man_a;
    logic [23:0] man_b;

    logic        sgn_2;
    logic        zero_2;
    logic [9:0]  exp_2;
    logic [47:0] prod_2;

    logic [9:0]  exp_3;
    logic [22:0] man_3;

    always_ff @(posedge clk) begin
        sgn_1  <= a[31] ^ b[31];
        zero_1 <= (a[30:23] == 8'd0) || (b[30:23] == 8'd0);
        exp_1  <= {2'b00, a[30:23]} + {2'b00, b[30:23]} - 10'(EXP_BIAS);
        man_a  <= {1'b1, a[22:0]};
        man_b  <= {1'b1, b[22:0]};

        sgn_2  <= sgn_1;
        zero_2 <= zero_1;
        exp_2  <= exp_1;
        prod_2 <= man_a * man_b;
    end

    // Product lies in [1, 4), at most one bit of shift
    always_comb begin
        if (prod_2[47]) begin
            exp_3 = exp_2 + 10'd1;
            man_3 = prod_2[46:24];
        end else begin
            exp_3 = exp_2;
            man_3 = prod_2[45:23];
        end
        if (zero_2 || exp_3[9] || exp_3 == 10'd0) begin
            product = {sgn_2, 31'd0};
        end else begin
            product = {sgn_2, exp_3[7:0], man_3};
        end
    end

endmodule

/* verilog/fp_convert.sv */
`timescale 1ns/1ns

module fp_convert (
    input  logic                     clk,
    input  logic [fpu_pkg::FLEN-1:0] fval,
    input  logic                     is_cvrt,
    input  logic [31:0]              ival,
    output logic [31:0]              to_int,
    output logic [fpu_pkg::FLEN-1:0] to_float
);
    import fpu_pkg::*;

    logic [7:0]  f_exp;
    logic [31:0] f_mag;
    logic [31:0] f_int;

    logic [31:0] i_abs;
    logic [4:0]  i_pos;
    logic        neg_q;
    logic        zero_q;
    logic [31:0] abs_q;
    logic [4:0]  pos_q;
    logic [31:0] i_norm;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Float to int, toward zero
    assign f_exp = fval[30:23];
    assign f_mag = {1'b1, fval[22:0], 8'd0} >> (8'(EXP_BIAS + 31) - f_exp);

    always_comb begin
        if (f_exp < 8'(EXP_BIAS)) begin
            f_int = '0;                               // Below one
        end else if (f_exp >= 8'(EXP_BIAS + 31)) begin
            f_int = fval[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end else begin
            f_int = fval[31] ? -f_mag : f_mag;
        end
    end

    always_ff @(posedge clk) begin
        to_int <= is_cvrt ? f_int : fval;             // fmv.x.w passes raw bits
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Int to float
    assign i_abs = ival[31] ? -ival : ival;

    always_comb begin
        i_pos = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (i_abs[i]) begin
                i_pos = 5'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        neg_q  <= ival[31];
        zero_q <= (ival == 32'd0);
        abs_q  <= i_abs;
        pos_q  <= i_pos;
    end

    assign i_norm   = abs_q << (5'd31 - pos_q);
    assign to_float = zero_q ? '0 : {neg_q, 8'(EXP_BIAS) + {3'd0, pos_q}, i_norm[30:8]};

endmodule

/* verilog/fpu.sv */
`timescale 1ns/1ns

module fpu (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     is_legl,
    input  logic [31:0]              inst,
    input  logic [fpu_pkg::FLEN-1:0] from_intreg,
    input  logic [fpu_pkg::FLEN-1:0] from_mem,
    output logic [fpu_pkg::FLEN-1:0] to_mem,
    output logic [fpu_pkg::FLEN-1:0] to_intreg,
    output logic                     enable_ftoi,
    output logic                     hazard
);
    import fpu_pkg::*;

    logic reg_write, is_sub, is_adsb, is_mult, is_load;
    logic is_cvif, is_ftoi, is_cvrt, use_rs1, use_rs2;
    rdy_t rdy;

    // Flag pipelines, index is the stage
    logic [4:1]        legl_p;
    logic [4:1]        write_p;
    logic [4:1]        wr_p;
    logic [2:1]        adsb_p;
    logic [2:1]        cvif_p;
    logic [2:1]        ftoi_p;
    logic [3:1]        mult_p;
    logic [3:1]        load_p;
    logic              sub_1;
    logic              cvrt_1;
    rdy_t              rdy_p [1:3];
    logic [REG_AW-1:0] rd_p  [1:4];

    logic [FLEN-1:0] rdata1, rdata2, ope1, ope2;
    logic [1:0]      fwd1_sel, fwd2_sel;
    logic [FLEN-1:0] result_2, result_3, result_4, mem_q;
    logic [FLEN-1:0] addsub_out, mult_out, cvif_out;

    fpu_decode u_decode (
        .opcode(inst[6:0]), .funct5(inst[31:27]), .funct3(inst[14:12]),
        .reg_write(reg_write), .is_sub(is_sub), .is_adsb(is_adsb), .is_mult(is_mult),
        .is_load(is_load), .is_cvif(is_cvif), .is_ftoi(is_ftoi), .is_cvrt(is_cvrt),
        .use_rs1(use_rs1), .use_rs2(use_rs2), .rdy(rdy)
    );

    fpu_dependency u_dep (
        .clk(clk), .rs1(inst[19:15]), .rs2(inst[24:20]), .use_rs1(use_rs1), .use_rs2(use_rs2),
        .rd_1(rd_p[1]), .rd_2(rd_p[2]), .rd_3(rd_p[3]), .rd_4(rd_p[4]),
        .wr_1(wr_p[1]), .wr_2(wr_p[2]), .wr_3(wr_p[3]), .wr_4(wr_p[4]),
        .rdy_1(rdy_p[1]), .rdy_2(rdy_p[2]), .rdy_3(rdy_p[3]),
        .hazard(hazard), .fwd1_sel(fwd1_sel), .fwd2_sel(fwd2_sel)
    );

    float_register u_freg (
        .clk(clk), .rs1(inst[19:15]), .rs2(inst[24:20]), .rd(rd_p[4]),
        .wdata(result_4), .we(wr_p[4]), .rdata1(rdata1), .rdata2(rdata2)
    );

    fp_addsub u_addsub (.clk(clk), .a(ope1), .b(ope2), .is_sub(sub_1), .sum(addsub_out));
    fp_mult u_mult (.clk(clk), .a(ope1), .b(ope2), .product(mult_out));
    fp_convert u_cvt (
        .clk(clk), .fval(ope1), .is_cvrt(cvrt_1), .ival(from_intreg),
        .to_int(to_intreg), .to_float(cvif_out)
    );

    function automatic logic [FLEN-1:0] fwd_pick(input logic [1:0] sel,
                                                input logic [FLEN-1:0] rdata);
        case (sel)
            2'd1:    fwd_pick = result_2;
            2'd2:    fwd_pick = result_3;
            2'd3:    fwd_pick = result_4;
            default: fwd_pick = rdata;
        endcase
    endfunction

    always_comb begin
        ope1 = fwd_pick(fwd1_sel, rdata1);
        ope2 = fwd_pick(fwd2_sel, rdata2);
    end

    assign wr_p        = legl_p & write_p;
    assign enable_ftoi = legl_p[2] & ftoi_p[2];
    assign to_mem      = ope2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            legl_p  <= '0;
            write_p <= '0;
            adsb_p  <= '0;
            cvif_p  <= '0;
            ftoi_p  <= '0;
            mult_p  <= '0;
            load_p  <= '0;
            sub_1   <= 1'b0;
            cvrt_1  <= 1'b0;
            rdy_p   <= '{default: RDY_2};
        end else begin
            legl_p   <= {legl_p[3:1], is_legl & ~hazard};  // Stalled slot is a bubble
            write_p  <= {write_p[3:1], reg_write};
            adsb_p   <= {adsb_p[1], is_adsb};
            cvif_p   <= {cvif_p[1], is_cvif};
            ftoi_p   <= {ftoi_p[1], is_ftoi};
            mult_p   <= {mult_p[2:1], is_mult};
            load_p   <= {load_p[2:1], is_load};
            sub_1    <= is_sub;
            cvrt_1   <= is_cvrt;
            rdy_p[1] <= rdy;
            rdy_p[2] <= rdy_p[1];
            rdy_p[3] <= rdy_p[2];
        end
    end

    // Result chain
    always_ff @(posedge clk) begin
        rd_p[1]  <= inst[11:7];
        rd_p[2]  <= rd_p[1];
        rd_p[3]  <= rd_p[2];
        rd_p[4]  <= rd_p[3];
        mem_q    <= from_mem;
        result_2 <= from_intreg;                  // fmv.w.x
        result_3 <= adsb_p[2] ? addsub_out : cvif_p[2] ? cvif_out : result_2;
        result_4 <= mult_p[3] ? mult_out : load_p[3] ? mem_q : result_3;
    end

endmodule

/* bench/fpu_tb.sv */
`timescale 1ns/1ns

module fpu_tb;
    import fpu_pkg::*;

    logic        clk;
    logic        rst;
    logic        is_legl;
    logic [31:0] inst;
    logic [31:0] from_intreg;
    logic [31:0] from_mem;
    wire  [31:0] to_mem;
    wire  [31:0] to_intreg;
    wire         enable_ftoi;
    wire         hazard;

    int errs;
    int test_errs;
    int tests_run;
    bit saw_hazard;

    fpu uut (
        .clk(clk), .rst(rst), .is_legl(is_legl), .inst(inst),
        .from_intreg(from_intreg), .from_mem(from_mem), .to_mem(to_mem),
        .to_intreg(to_intreg), .enable_ftoi(enable_ftoi), .hazard(hazard)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoders for single precision
    function automatic logic [31:0] r_type(input logic [4:0] f5, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f5, 2'b00, rs2, rs1, f3, rd, OP_FP};
    endfunction

    function automatic logic [31:0] flw_enc(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'd0, rs1, 3'b010, rd, OP_FLW};
    endfunction

    function automatic logic [31:0] fsw_enc(input logic [4:0] rs2, input logic [4:0] rs1);
        return {7'd0, rs2, rs1, 3'b010, 5'd0, OP_FSW};
    endfunction

    // Real to single bits with truncation and flush to zero
    function automatic logic [31:0] to_bits(input real r);
        real         m;
        int          e;
        logic        s;
        logic [22:0] mant;
        if (r == 0.0)
            return 32'd0;
        s = (r < 0.0);
        m = s ? -r : r;
        e = 127;
        while (m >= 2.0) begin
            m = m / 2.0;
            e++;
        end
        while (m < 1.0) begin
            m = m * 2.0;
            e--;
        end
        if (e <= 0)
            return {s, 31'd0};
        mant = 23'($rtoi((m - 1.0) * 8388608.0));
        return {s, 8'(e), mant};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, test_errs);
        errs += test_errs;
        tests_run++;
        test_errs = 0;
    endtask

    task automatic idle(input int n);
        inst    = 32'd0;
        is_legl = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // Returns on the falling edge with the instruction in stage 1
    task automatic issue(input logic [31:0] word, input bit legal);
        int n;
        inst    = word;
        is_legl = legal;
        n       = 0;
        #1;
        while (hazard) begin
            saw_hazard = 1'b1;
            n++;
            if (n > 50)
                timeout("hazard to drop");
            @(negedge clk);
            #1;
        end
        @(negedge clk);
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] bits);
        from_intreg = bits;
        issue(r_type(F5_MV_WX, 5'd0, 5'd0, 3'b000, rd), 1'b1);
        idle(6);
    endtask

    task automatic ftoi_read(input logic [31:0] word, output logic [31:0] val);
        int n;
        issue(word, 1'b1);
        idle(0);
        n = 0;
        while (!enable_ftoi) begin
            n++;
            if (n > 20)
                timeout("enable_ftoi");
            @(negedge clk);
        end
        val = to_intreg;
        idle(4);
    endtask

    task automatic read_reg(input logic [4:0] rs, output logic [31:0] val);
        ftoi_read(r_type(F5_MV_XW, 5'd0, rs, 3'b000, 5'd0), val);
    endtask

    // Result of one op on f1 and f2 lands in f4
    task automatic run_op(input logic [4:0] f5, input real a, input real b,
                          input logic [31:0] exp, input string name);
        logic [31:0] v;
        write_reg(5'd1, to_bits(a));
        write_reg(5'd2, to_bits(b));
        issue(r_type(f5, 5'd2, 5'd1, 3'b001, 5'd4), 1'b1);
        idle(6);
        read_reg(5'd4, v);
        check(name, v, exp);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic reset_and_illegal();
        logic [31:0] v;
        inst    = r_type(F5_ADD, 5'd0, 5'd0, 3'b001, 5'd0);  // Sources match the flw rd
        is_legl = 1'b0;
        #1;
        check("enable_ftoi", {31'd0, enable_ftoi}, 32'd0);
        check("hazard", {31'd0, hazard}, 32'd0);
        @(negedge clk);
        write_reg(5'd3, 32'h3fc0_0000);
        from_intreg = 32'hdead_beef;
        issue(r_type(F5_MV_WX, 5'd0, 5'd0, 3'b000, 5'd3), 1'b0);  // Dropped
        idle(6);
        read_reg(5'd3, v);
        check("f3", v, 32'h3fc0_0000);
        end_test("reset_and_illegal");
    endtask

    task automatic move_and_addsub();
        real         a [4] = '{1.5, -3.0, 7.25, 0.5};
        real         b [4] = '{2.0, 1.25, -7.25, -4.5};
        logic [4:0]  r;
        logic [31:0] bits;
        logic [31:0] v;
        repeat (4) begin
            r    = 5'(1 + $urandom % 31);
            bits = $urandom;
            write_reg(r, bits);
            read_reg(r, v);
            check("fmv bits", v, bits);
        end
        foreach (a[i]) begin
            run_op(F5_ADD, a[i], b[i], to_bits(a[i] + b[i]), "fadd.s");
            run_op(F5_SUB, a[i], b[i], to_bits(a[i] - b[i]), "fsub.s");
        end
        end_test("move_and_addsub");
    endtask

    task automatic multiply();
        real a [4] = '{1.5, -2.5, 0.0, 3.0};
        real b [4] = '{2.25, 4.0, 3.5, -0.125};
        foreach (a[i])
            run_op(F5_MUL, a[i], b[i], to_bits(a[i] * b[i]), "fmul.s");
        run_op(F5_MUL, 2.0 ** (-70), 2.0 ** (-70), 32'd0, "fmul.s underflow");
        end_test("multiply");
    endtask

    task automatic ftoi_of(input real f, input logic [31:0] exp);
        logic [31:0] v;
        write_reg(5'd7, to_bits(f));
        ftoi_read(r_type(F5_CVT_WS, 5'd0, 5'd7, 3'b001, 5'd0), v);
        check("fcvt.w.s", v, exp);
    endtask

    task automatic convert();
        int          iv;
        logic [31:0] v;
        repeat (4) begin
            iv = int'($urandom % 32'h0100_0000);
            if ($urandom % 2 == 1)
                iv = -iv;
            from_intreg = iv;
            issue(r_type(F5_CVT_SW, 5'd0, 5'd0, 3'b001, 5'd6), 1'b1);
            idle(6);
            read_reg(5'd6, v);
            check("fcvt.s.w", v, to_bits(real'(iv)));
            ftoi_read(r_type(F5_CVT_WS, 5'd0, 5'd6, 3'b001, 5'd0), v);
            check("fcvt.w.s", v, iv);
        end
        ftoi_of(2.75, 32'd2);
        ftoi_of(-2.75, 32'hffff_fffe);
        ftoi_of(2.0 ** 40, 32'h7fff_ffff);   // Saturates
        ftoi_of(-(2.0 ** 40), 32'h8000_0000);
        end_test("convert");
    endtask

    task automatic dependent_pairs();
        logic [31:0] v;
        write_reg(5'd1, to_bits(1.5));
        write_reg(5'd2, to_bits(2.25));
        saw_hazard = 1'b0;
        issue(r_type(F5_ADD, 5'd2, 5'd1, 3'b001, 5'd3), 1'b1);
        idle(1);  // One slot apart so f3 comes from result_3
        issue(r_type(F5_ADD, 5'd1, 5'd3, 3'b001, 5'd4), 1'b1);
        idle(6);
        check("hazard seen on add chain", {31'd0, saw_hazard}, 32'd0);
        read_reg(5'd4, v);
        check("f4", v, to_bits(5.25));

        saw_hazard = 1'b0;
        issue(r_type(F5_MUL, 5'd2, 5'd1, 3'b001, 5'd5), 1'b1);
        issue(r_type(F5_ADD, 5'd2, 5'd5, 3'b001, 5'd6), 1'b1);
        idle(6);
        check("hazard seen on mul chain", {31'd0, saw_hazard}, 32'd1);
        read_reg(5'd6, v);
        check("f6", v, to_bits(5.625));

        from_mem = to_bits(-6.5);
        issue(flw_enc(5'd7, 5'd0), 1'b1);
        issue(fsw_enc(5'd7, 5'd0), 1'b1);
        check("to_mem", to_mem, to_bits(-6.5));
        idle(6);
        read_reg(5'd7, v);
        check("f7", v, to_bits(-6.5));
        end_test("dependent_pairs");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(32'h4832));
        errs        = 0;
        test_errs   = 0;
        tests_run   = 0;
        rst         = 1'b1;
        is_legl     = 1'b1;  // Legal traffic that reset has to squash
        inst        = r_type(F5_CVT_WS, 5'd0, 5'd0, 3'b001, 5'd0);
        from_intreg = 32'd0;
        from_mem    = 32'd0;
        repeat (15) @(negedge clk);
        inst = flw_enc(5'd0, 5'd0);
        @(negedge clk);
        rst = 1'b0;
        reset_and_illegal();
        move_and_addsub();
        multiply();
        convert();
        dependent_pairs();
        $display("%0d tests run, %0d errors", tests_run, errs);
        if (errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/fpu_pkg.sv
verilog/fpu_decode.sv
verilog/fpu_dependency.sv
verilog/float_register.sv
verilog/fp_addsub.sv
verilog/fp_mult.sv
verilog/fp_convert.sv
verilog/fpu.sv
bench/fpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fpu_tb -f sources.f -o fpu_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fpu_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB PASSED" sim.log; then
    exit 0
fi
exit 1
